// ==== axi_mem_pkg.sv ====
package axi_mem_pkg;

    // bus widths
    localparam int addr_w = 32;
    localparam int data_w = 32;
    localparam int strb_w = data_w / 8;

    // AXI response codes, only the two this slave returns
    typedef enum logic [1:0] {
        resp_okay   = 2'b00,
        resp_slverr = 2'b10
    } axi_resp_t;

    // address decode result
    typedef enum logic [1:0] {
        region_flash = 2'd0,
        region_sdram = 2'd1,
        region_uart  = 2'd2,
        region_none  = 2'd3
    } region_t;

    // region base addresses
    localparam logic [addr_w-1:0] flash_base = 32'h3000_0000;
    localparam logic [addr_w-1:0] sdram_base = 32'ha000_0000;
    localparam logic [addr_w-1:0] uart_base  = 32'h1000_0000;

    // console window, byte 0 carries the character
    localparam int uart_bytes = 8;

endpackage

// ==== mem_port_if.sv ====
`timescale 1ns/1ps

interface mem_port_if;
    import axi_mem_pkg::*;

    // read half, answered one cycle after rd_en
    logic              rd_en;
    logic [addr_w-1:0] rd_addr;
    logic [data_w-1:0] rd_data;
    logic              rd_err;

    // write half, wr_err is valid in the same cycle as wr_en
    logic              wr_en;
    logic [addr_w-1:0] wr_addr;
    logic [data_w-1:0] wr_data;
    logic [strb_w-1:0] wr_strb;
    logic              wr_err;

    modport reader (output rd_en, rd_addr, input rd_data, rd_err);

    modport writer (output wr_en, wr_addr, wr_data, wr_strb, input wr_err);

    modport router (
        input  rd_en, rd_addr, wr_en, wr_addr, wr_data, wr_strb,
        output rd_data, rd_err, wr_err
    );

endinterface

// ==== word_store.sv ====
`timescale 1ns/1ps

module word_store #(
    parameter int words = 1024
) (
    input  logic                            clock,
    input  logic                            en,
    input  logic                            we,
    input  logic [$clog2(words)-1:0]        index,
    input  logic [$clog2(words)-1:0]        windex,
    input  logic [axi_mem_pkg::data_w-1:0]  wdata,
    input  logic [axi_mem_pkg::strb_w-1:0]  strb,
    output logic [axi_mem_pkg::data_w-1:0]  rdata
);
    import axi_mem_pkg::*;

    logic [data_w-1:0] mem [words];

    // read port, output holds while en is low
    always_ff @(posedge clock) begin
        if (en) begin
            rdata <= mem[index];
        end
    end

    // write port, only strobed bytes change
    always_ff @(posedge clock) begin
        if (we) begin
            for (int b = 0; b < strb_w; b++) begin
                if (strb[b]) begin
                    mem[windex][8*b +: 8] <= wdata[8*b +: 8];
                end
            end
        end
    end

endmodule

// ==== region_router.sv ====
`timescale 1ns/1ps

module region_router #(
    parameter int flash_words = 1024,
    parameter int sdram_words = 1024
) (
    input  logic        clock,
    input  logic        rst_n,
    mem_port_if.router  mem,
    output logic [7:0]  uart_data,
    output logic        uart_valid
);
    import axi_mem_pkg::*;

    localparam int flash_idx_w = $clog2(flash_words);
    localparam int sdram_idx_w = $clog2(sdram_words);
    localparam logic [addr_w-1:0] flash_size = addr_w'(flash_words * 4);
    localparam logic [addr_w-1:0] sdram_size = addr_w'(sdram_words * 4);
    localparam logic [addr_w-1:0] uart_size  = addr_w'(uart_bytes);

    region_t           rd_region;
    region_t           wr_region;
    region_t           rd_region_q;
    logic [addr_w-1:0] rd_flash_off;
    logic [addr_w-1:0] rd_sdram_off;
    logic [addr_w-1:0] wr_flash_off;
    logic [addr_w-1:0] wr_sdram_off;
    logic [data_w-1:0] flash_rdata;
    logic [data_w-1:0] sdram_rdata;

    function automatic region_t decode(input logic [addr_w-1:0] addr);
        if (addr >= flash_base && (addr - flash_base) < flash_size) begin
            return region_flash;
        end
        if (addr >= sdram_base && (addr - sdram_base) < sdram_size) begin
            return region_sdram;
        end
        if (addr >= uart_base && (addr - uart_base) < uart_size) begin
            return region_uart;
        end
        return region_none;
    endfunction

    assign rd_region    = decode(mem.rd_addr);
    assign wr_region    = decode(mem.wr_addr);
    assign rd_flash_off = mem.rd_addr - flash_base;
    assign rd_sdram_off = mem.rd_addr - sdram_base;
    assign wr_flash_off = mem.wr_addr - flash_base;
    assign wr_sdram_off = mem.wr_addr - sdram_base;

    word_store #(.words(flash_words)) flash_store (
        .clock  (clock),
        .en     (mem.rd_en && rd_region == region_flash),
        .we     (mem.wr_en && wr_region == region_flash),
        .index  (rd_flash_off[flash_idx_w+1:2]),
        .windex (wr_flash_off[flash_idx_w+1:2]),
        .wdata  (mem.wr_data),
        .strb   (mem.wr_strb),
        .rdata  (flash_rdata)
    );

    word_store #(.words(sdram_words)) sdram_store (
        .clock  (clock),
        .en     (mem.rd_en && rd_region == region_sdram),
        .we     (mem.wr_en && wr_region == region_sdram),
        .index  (rd_sdram_off[sdram_idx_w+1:2]),
        .windex (wr_sdram_off[sdram_idx_w+1:2]),
        .wdata  (mem.wr_data),
        .strb   (mem.wr_strb),
        .rdata  (sdram_rdata)
    );

    // remember where the read went, to pick the store output next cycle
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            rd_region_q <= region_none;
        end else if (mem.rd_en) begin
            rd_region_q <= rd_region;
        end
    end

    always_comb begin
        case (rd_region_q)
            region_flash: mem.rd_data = flash_rdata;
            region_sdram: mem.rd_data = sdram_rdata;
            default:      mem.rd_data = '0;
        endcase
    end

    // console is write-only
    assign mem.rd_err = (rd_region_q == region_uart) || (rd_region_q == region_none);
    assign mem.wr_err = (wr_region == region_none);

    assign uart_valid = mem.wr_en && (wr_region == region_uart);
    assign uart_data  = mem.wr_strb[0] ? mem.wr_data[7:0] : 8'h00;

endmodule

// ==== axi_read_engine.sv ====
`timescale 1ns/1ps

module axi_read_engine (
    input  logic                            clock,
    input  logic                            rst_n,
    input  logic                            arvalid,
    output logic                            arready,
    input  logic [axi_mem_pkg::addr_w-1:0]  araddr,
    input  logic [7:0]                      arlen,
    output logic                            rvalid,
    input  logic                            rready,
    output logic [axi_mem_pkg::data_w-1:0]  rdata,
    output axi_mem_pkg::axi_resp_t          rresp,
    output logic                            rlast,
    mem_port_if.reader                      mem
);
    import axi_mem_pkg::*;

    typedef enum logic [1:0] {
        rd_idle,
        rd_fetch,
        rd_send
    } rd_state_t;

    rd_state_t         state;
    logic [addr_w-1:0] addr_q;
    logic [7:0]        len_q;
    logic [7:0]        beat_q;
    logic              fresh_q;
    logic [data_w-1:0] rdata_q;
    axi_resp_t         rresp_q;
    axi_resp_t         beat_resp;

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            state   <= rd_idle;
            fresh_q <= 1'b0;
            beat_q  <= '0;
        end else begin
            case (state)
                rd_idle: begin
                    if (arvalid) begin
                        beat_q <= '0;
                        state  <= rd_fetch;
                    end
                end
                rd_fetch: begin
                    fresh_q <= 1'b1;
                    state   <= rd_send;
                end
                rd_send: begin
                    fresh_q <= 1'b0;
                    if (rready) begin
                        if (beat_q == len_q) begin
                            state <= rd_idle;
                        end else begin
                            beat_q <= beat_q + 8'd1;
                            state  <= rd_fetch;
                        end
                    end
                end
                default: state <= rd_idle;
            endcase
        end
    end

    // burst address and length, next beat is 4 bytes on
    always_ff @(posedge clock) begin
        if (state == rd_idle && arvalid) begin
            addr_q <= araddr;
            len_q  <= arlen;
        end else if (state == rd_send && rready && beat_q != len_q) begin
            addr_q <= addr_q + 32'd4;
        end
    end

    assign beat_resp = mem.rd_err ? resp_slverr : resp_okay;

    // capture the returned word on the first send cycle, then hold it
    always_ff @(posedge clock) begin
        if (fresh_q) begin
            rdata_q <= mem.rd_data;
            rresp_q <= beat_resp;
        end
    end

    assign arready = (state == rd_idle);
    assign mem.rd_en   = (state == rd_fetch);
    assign mem.rd_addr = addr_q;

    assign rvalid = (state == rd_send);
    assign rdata  = fresh_q ? mem.rd_data : rdata_q;
    assign rresp  = fresh_q ? beat_resp : rresp_q;
    assign rlast  = (state == rd_send) && (beat_q == len_q);

endmodule

// ==== axi_write_engine.sv ====
`timescale 1ns/1ps

module axi_write_engine (
    input  logic                            clock,
    input  logic                            rst_n,
    input  logic                            awvalid,
    output logic                            awready,
    input  logic [axi_mem_pkg::addr_w-1:0]  awaddr,
    input  logic                            wvalid,
    output logic                            wready,
    input  logic [axi_mem_pkg::data_w-1:0]  wdata,
    input  logic [axi_mem_pkg::strb_w-1:0]  wstrb,
    output logic                            bvalid,
    input  logic                            bready,
    output axi_mem_pkg::axi_resp_t          bresp,
    mem_port_if.writer                      mem
);
    import axi_mem_pkg::*;

    typedef enum logic [2:0] {
        wr_idle,
        wr_wait_addr,
        wr_wait_data,
        wr_write,
        wr_respond
    } wr_state_t;

    wr_state_t         state;
    logic [addr_w-1:0] addr_q;
    logic [data_w-1:0] data_q;
    logic [strb_w-1:0] strb_q;
    axi_resp_t         bresp_q;
    logic              aw_fire;
    logic              w_fire;

    assign awready = (state == wr_idle) || (state == wr_wait_addr);
    assign wready  = (state == wr_idle) || (state == wr_wait_data);
    assign aw_fire = awvalid && awready;
    assign w_fire  = wvalid && wready;

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            state <= wr_idle;
        end else begin
            case (state)
                wr_idle: begin
                    if (aw_fire && w_fire) begin
                        state <= wr_write;
                    end else if (aw_fire) begin
                        state <= wr_wait_data;
                    end else if (w_fire) begin
                        state <= wr_wait_addr;
                    end
                end
                wr_wait_addr: begin
                    if (aw_fire) begin
                        state <= wr_write;
                    end
                end
                wr_wait_data: begin
                    if (w_fire) begin
                        state <= wr_write;
                    end
                end
                wr_write: state <= wr_respond;
                wr_respond: begin
                    if (bready) begin
                        state <= wr_idle;
                    end
                end
                default: state <= wr_idle;
            endcase
        end
    end

    // address and data arrive independently
    always_ff @(posedge clock) begin
        if (aw_fire) begin
            addr_q <= awaddr;
        end
        if (w_fire) begin
            data_q <= wdata;
            strb_q <= wstrb;
        end
        if (state == wr_write) begin
            bresp_q <= mem.wr_err ? resp_slverr : resp_okay;
        end
    end

    assign mem.wr_en   = (state == wr_write);
    assign mem.wr_addr = addr_q;
    assign mem.wr_data = data_q;
    assign mem.wr_strb = strb_q;

    assign bvalid = (state == wr_respond);
    assign bresp  = bresp_q;

endmodule

// ==== axi_mem_top.sv ====
`timescale 1ns/1ps

module axi_mem_top #(
    parameter int flash_words = 1024,
    parameter int sdram_words = 1024
) (
    input  logic                            clock,
    input  logic                            rst_n,
    // read address and data
    input  logic                            arvalid,
    output logic                            arready,
    input  logic [axi_mem_pkg::addr_w-1:0]  araddr,
    input  logic [7:0]                      arlen,
    output logic                            rvalid,
    input  logic                            rready,
    output logic [axi_mem_pkg::data_w-1:0]  rdata,
    output axi_mem_pkg::axi_resp_t          rresp,
    output logic                            rlast,
    // write address, data and response
    input  logic                            awvalid,
    output logic                            awready,
    input  logic [axi_mem_pkg::addr_w-1:0]  awaddr,
    input  logic                            wvalid,
    output logic                            wready,
    input  logic [axi_mem_pkg::data_w-1:0]  wdata,
    input  logic [axi_mem_pkg::strb_w-1:0]  wstrb,
    output logic                            bvalid,
    input  logic                            bready,
    output axi_mem_pkg::axi_resp_t          bresp,
    // console
    output logic [7:0]                      uart_data,
    output logic                            uart_valid
);

    mem_port_if mem_bus ();

    axi_read_engine u_read_engine (
        .clock   (clock),
        .rst_n   (rst_n),
        .arvalid (arvalid),
        .arready (arready),
        .araddr  (araddr),
        .arlen   (arlen),
        .rvalid  (rvalid),
        .rready  (rready),
        .rdata   (rdata),
        .rresp   (rresp),
        .rlast   (rlast),
        .mem     (mem_bus.reader)
    );

    axi_write_engine u_write_engine (
        .clock   (clock),
        .rst_n   (rst_n),
        .awvalid (awvalid),
        .awready (awready),
        .awaddr  (awaddr),
        .wvalid  (wvalid),
        .wready  (wready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .bvalid  (bvalid),
        .bready  (bready),
        .bresp   (bresp),
        .mem     (mem_bus.writer)
    );

    region_router #(
        .flash_words (flash_words),
        .sdram_words (sdram_words)
    ) u_router (
        .clock      (clock),
        .rst_n      (rst_n),
        .mem        (mem_bus.router),
        .uart_data  (uart_data),
        .uart_valid (uart_valid)
    );

endmodule

// ==== tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int period_ns    = 8,
    parameter int reset_cycles = 2
) (
    output logic clock,
    output logic rst_n
);

    initial begin
        clock = 1'b0;
        forever #(period_ns / 2) clock = ~clock;
    end

    // reset released on a rising edge
    initial begin
        rst_n = 1'b0;
        repeat (reset_cycles) @(posedge clock);
        rst_n <= 1'b1;
    end

endmodule

// ==== axi_mem_asserts.sv ====
`timescale 1ns/1ps

module axi_mem_asserts (
    input logic                            clock,
    input logic                            rst_n,
    input logic                            rvalid,
    input logic                            rready,
    input logic [axi_mem_pkg::data_w-1:0]  rdata,
    input axi_mem_pkg::axi_resp_t          rresp,
    input logic                            rlast,
    input logic                            bvalid,
    input logic                            bready,
    input logic                            uart_valid
);

    // R payload holds while the master stalls
    r_hold: assert property (@(posedge clock) disable iff (!rst_n)
        rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp) && $stable(rlast))
        else $error("R channel changed while rready was low");

    r_last_valid: assert property (@(posedge clock) disable iff (!rst_n)
        rlast |-> rvalid)
        else $error("rlast high without rvalid");

    b_hold: assert property (@(posedge clock) disable iff (!rst_n)
        bvalid && !bready |=> bvalid)
        else $error("bvalid dropped before bready");

    // one pulse per console write
    uart_pulse: assert property (@(posedge clock) disable iff (!rst_n)
        uart_valid |=> !uart_valid)
        else $error("uart_valid high for two cycles in a row");

endmodule

bind axi_mem_top axi_mem_asserts u_asserts (.*);

// ==== axi_mem_tb.sv ====
`timescale 1ns/1ps

module axi_mem_tb;
    import axi_mem_pkg::*;

    localparam string golden_file   = "axi_mem_golden.txt";
    localparam int rec_words        = 10;
    localparam int max_words        = 256;
    localparam int timeout_cycles   = 200;
    localparam int unsigned rand_seed = 38875;

    logic              clock;
    logic              rst_n;
    logic              arvalid;
    logic              arready;
    logic [addr_w-1:0] araddr;
    logic [7:0]        arlen;
    logic              rvalid;
    logic              rready;
    logic [data_w-1:0] rdata;
    axi_resp_t         rresp;
    logic              rlast;
    logic              awvalid;
    logic              awready;
    logic [addr_w-1:0] awaddr;
    logic              wvalid;
    logic              wready;
    logic [data_w-1:0] wdata;
    logic [strb_w-1:0] wstrb;
    logic              bvalid;
    logic              bready;
    axi_resp_t         bresp;
    logic [7:0]        uart_data;
    logic              uart_valid;

    logic [31:0]       golden [max_words];
    logic [data_w-1:0] beat_data [max_words];
    axi_resp_t         beat_resp [max_words];
    logic              beat_last [max_words];
    int                uart_total = 0;
    logic [7:0]        uart_last = 8'h00;
    int                pass_count;
    int                fail_count;
    bit                stall_mode;
    bit                timed_out;

    tb_clock_gen #(.period_ns(8), .reset_cycles(2)) u_clock_gen (
        .clock (clock),
        .rst_n (rst_n)
    );

    axi_mem_top #(.flash_words(1024), .sdram_words(1024)) DUT (.*);

    // console monitor, sampled mid-cycle
    always @(negedge clock) begin
        if (rst_n && uart_valid) begin
            uart_total = uart_total + 1;
            uart_last  = uart_data;
        end
    end

    // ready for this cycle, random only in the stall pass
    function automatic logic ready_draw();
        return stall_mode ? (($urandom % 3) != 0) : 1'b1;
    endfunction

    task automatic check_timeout(input int waited, input string what);
        if (waited > timeout_cycles && !timed_out) begin
            $display("timeout at %0t: no %s within %0d cycles", $time, what, timeout_cycles);
            timed_out = 1'b1;
        end
    endtask

    task automatic write_op(input logic [31:0] addr, input logic [31:0] data,
                            input logic [3:0] strb, output axi_resp_t resp);
        int waited;
        int lag;
        int aw_delay;
        int w_delay;
        bit aw_done;
        bit w_done;
        bit aw_hs;
        bit w_hs;
        bit got;
        aw_done = 1'b0;
        w_done  = 1'b0;
        got     = 1'b0;
        waited  = 0;
        resp    = resp_okay;
        // in the stall pass either channel may trail the other
        lag      = stall_mode ? int'($urandom % 5) : 0;
        w_delay  = (lag <= 2) ? lag : 0;
        aw_delay = (lag > 2) ? lag - 2 : 0;
        @(posedge clock);
        awvalid <= (aw_delay == 0);
        awaddr  <= addr;
        wdata   <= data;
        wstrb   <= strb;
        wvalid  <= (w_delay == 0);
        while (!(aw_done && w_done) && !timed_out) begin
            @(negedge clock);
            aw_hs = awvalid && awready;
            w_hs  = wvalid && wready;
            @(posedge clock);
            if (aw_hs) begin
                awvalid <= 1'b0;
                aw_done = 1'b1;
            end
            if (w_hs) begin
                wvalid <= 1'b0;
                w_done = 1'b1;
            end
            if (aw_delay > 0) begin
                aw_delay--;
                if (aw_delay == 0) begin
                    awvalid <= 1'b1;
                end
            end
            if (w_delay > 0) begin
                w_delay--;
                if (w_delay == 0) begin
                    wvalid <= 1'b1;
                end
            end
            waited++;
            check_timeout(waited, "AW/W handshake");
        end
        waited = 0;
        while (!got && !timed_out) begin
            @(posedge clock);
            bready <= ready_draw();
            @(negedge clock);
            if (bvalid && bready) begin
                got  = 1'b1;
                resp = bresp;
            end
            waited++;
            check_timeout(waited, "B response");
        end
        @(posedge clock);
        bready <= 1'b0;
    endtask

    task automatic read_op(input logic [31:0] addr, input logic [7:0] len);
        int waited;
        bit done;
        bit hs;
        bit got;
        done   = 1'b0;
        waited = 0;
        @(posedge clock);
        arvalid <= 1'b1;
        araddr  <= addr;
        arlen   <= len;
        while (!done && !timed_out) begin
            @(negedge clock);
            hs = arvalid && arready;
            @(posedge clock);
            if (hs) begin
                arvalid <= 1'b0;
                done = 1'b1;
            end
            waited++;
            check_timeout(waited, "AR handshake");
        end
        for (int beat = 0; beat <= int'(len) && !timed_out; beat++) begin
            got    = 1'b0;
            waited = 0;
            while (!got && !timed_out) begin
                @(posedge clock);
                rready <= ready_draw();
                @(negedge clock);
                if (rvalid && rready) begin
                    got             = 1'b1;
                    beat_data[beat] = rdata;
                    beat_resp[beat] = rresp;
                    beat_last[beat] = rlast;
                end
                waited++;
                check_timeout(waited, "R beat");
            end
        end
        @(posedge clock);
        rready <= 1'b0;
    endtask

    task automatic run_record(input int base, input int test_num);
        logic [31:0] kind;
        logic [31:0] addr;
        logic [31:0] len;
        axi_resp_t   exp_resp;
        axi_resp_t   resp;
        int          errors;
        int          uart_before;
        kind     = golden[base];
        addr     = golden[base + 1];
        len      = golden[base + 2];
        exp_resp = axi_resp_t'(golden[base + 5][1:0]);
        errors   = 0;
        if (kind == 32'd1) begin
            uart_before = uart_total;
            write_op(addr, golden[base + 3], golden[base + 4][3:0], resp);
            if (resp != exp_resp) begin
                $display("ERROR %0t bresp: got %0d expected %0d", $time, resp, exp_resp);
                errors++;
            end
            if ((uart_total - uart_before) != int'(golden[base + 6])) begin
                $display("ERROR %0t uart_valid pulses: got %0d expected %0d", $time,
                         uart_total - uart_before, golden[base + 6]);
                errors++;
            end else if (golden[base + 6] != 0 && uart_last != golden[base + 7][7:0]) begin
                $display("ERROR %0t uart_data: got %h expected %h", $time, uart_last,
                         golden[base + 7][7:0]);
                errors++;
            end
        end else begin
            read_op(addr, len[7:0]);
            for (int b = 0; b <= int'(len) && !timed_out; b++) begin
                if (beat_resp[b] != exp_resp) begin
                    $display("ERROR %0t rresp beat %0d: got %0d expected %0d", $time, b,
                             beat_resp[b], exp_resp);
                    errors++;
                end
                // error reads carry no defined data
                if (exp_resp == resp_okay && beat_data[b] != golden[base + 6 + b]) begin
                    $display("ERROR %0t rdata beat %0d: got %h expected %h", $time, b,
                             beat_data[b], golden[base + 6 + b]);
                    errors++;
                end
                if (beat_last[b] != (b == int'(len))) begin
                    $display("ERROR %0t rlast beat %0d: got %0b expected %0b", $time, b,
                             beat_last[b], b == int'(len));
                    errors++;
                end
            end
        end
        if (timed_out) begin
            errors++;
        end
        if (errors == 0) begin
            pass_count++;
        end else begin
            fail_count++;
        end
        $display("test %0d %s %s addr %h: %s", test_num, stall_mode ? "stalled" : "plain",
                 kind == 32'd1 ? "write" : "read", addr, errors == 0 ? "passed" : "FAILED");
    endtask

    initial begin
        int waited;
        int base;
        int test_num;
        void'($urandom(rand_seed));
        arvalid    = 1'b0;
        araddr     = '0;
        arlen      = '0;
        rready     = 1'b0;
        awvalid    = 1'b0;
        awaddr     = '0;
        wvalid     = 1'b0;
        wdata      = '0;
        wstrb      = '0;
        bready     = 1'b0;
        pass_count = 0;
        fail_count = 0;
        stall_mode = 1'b0;
        timed_out  = 1'b0;
        test_num   = 0;
        for (int i = 0; i < max_words; i++) begin
            golden[i] = '0;
        end
        $readmemh(golden_file, golden);
        waited = 0;
        while (rst_n !== 1'b1 && !timed_out) begin
            @(posedge clock);
            waited++;
            check_timeout(waited, "reset release");
        end
        // second pass repeats the list with random ready stalls
        for (int pass = 0; pass < 2; pass++) begin
            stall_mode = (pass == 1);
            base = 0;
            while (base + rec_words <= max_words && golden[base] != 0 && !timed_out) begin
                run_record(base, test_num);
                base += rec_words;
                test_num++;
            end
        end
        $display("tests: %0d passed, %0d failed", pass_count, fail_count);
        if (fail_count == 0 && pass_count > 0 && !timed_out) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== axi_mem_golden.txt ====
// kind addr len wdata strb resp e0 e1 e2 e3   (kind 1 write, 2 read, 0 end; resp 0 okay, 2 slverr)
// reads expect e0..e3 per beat; writes expect e0 console pulses and e1 console byte
1 a0000010 0 12345678 f 0 0 0 0 0
2 a0000010 0 0 0 0 12345678 0 0 0
// partial strobe merge over a known word
1 a0000020 0 aabbccdd f 0 0 0 0 0
1 a0000020 0 11223344 5 0 0 0 0 0
2 a0000020 0 0 0 0 aa22cc44 0 0 0
// four flash words, then one burst over them
1 30000000 0 10000001 f 0 0 0 0 0
1 30000004 0 20000002 f 0 0 0 0 0
1 30000008 0 30000003 f 0 0 0 0 0
1 3000000c 0 40000004 f 0 0 0 0 0
2 30000000 3 0 0 0 10000001 20000002 30000003 40000004
// just past the end of sdram, then the last valid word
1 a0000ffc 0 cafef00d f 0 0 0 0 0
1 a0001000 0 deadbeef f 2 0 0 0 0
2 a0001000 0 0 0 2 0 0 0 0
2 20000000 0 0 0 2 0 0 0 0
2 a0000ffc 0 0 0 0 cafef00d 0 0 0
// console writes and a console read
1 10000000 0 00000041 f 0 1 41 0 0
1 10000000 0 12345a5a 1 0 1 5a 0 0
2 10000000 0 0 0 2 0 0 0 0
0 0 0 0 0 0 0 0 0 0

// ==== axi_mem.f ====
axi_mem_pkg.sv
mem_port_if.sv
word_store.sv
region_router.sv
axi_read_engine.sv
axi_write_engine.sv
axi_mem_top.sv
tb_clock_gen.sv
axi_mem_asserts.sv
axi_mem_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= axi_mem_tb
FILELIST  ?= axi_mem.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
PASS_MSG  ?= Simulation completed successfully

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# the run passes only when the pass line appears in the output
run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
